// ==== logic/router_pkg.sv ====
// router package: mesh size, tile ids, directions, opcodes and link structs
package router_pkg;

    // ==============================
    // mesh size
    // ==============================
    localparam int MESH_X_W = 2; // 4 columns
    localparam int MESH_Y_W = 2; // 4 rows

    typedef struct packed {
        logic [MESH_Y_W-1:0] y;
        logic [MESH_X_W-1:0] x;
    } t_tile_id;

    // output port of this router, or arbiter inside the next one
    typedef enum logic [2:0] {
        NORTH = 3'd0,
        EAST  = 3'd1,
        SOUTH = 3'd2,
        WEST  = 3'd3,
        LOCAL = 3'd4
    } t_dir;

    typedef enum logic [1:0] {
        RD     = 2'd0,
        WR     = 2'd1,
        RD_RSP = 2'd2,
        WR_RSP = 2'd3
    } t_opcode;

    // ==============================
    // link payload and ready
    // ==============================
    typedef struct packed {
        logic [31:0] data;
        logic [31:0] address;
        t_opcode     opcode;
        t_tile_id    requestor_id;
        t_tile_id    target_tile_id;
        t_dir        next_tile_fifo_arb_id; // arbiter to use in the receiving router
    } t_tile_trans;

    // one bit per arbiter of the receiving router, for traffic on this link
    typedef struct packed {
        logic north_arb;
        logic east_arb;
        logic south_arb;
        logic west_arb;
        logic local_arb;
    } t_fab_ready;

endpackage

// ==== logic/fifo.sv ====
// transaction fifo: circular buffer with occupancy count, head visible after write
module fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    push,
    input  router_pkg::t_tile_trans push_data,
    input  logic                    pop,
    output router_pkg::t_tile_trans head,
    output logic                    empty,
    output logic                    full
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    router_pkg::t_tile_trans mem [FIFO_DEPTH];
    logic [PTR_W-1:0]        rd_ptr;
    logic [PTR_W-1:0]        wr_ptr;
    logic [PTR_W:0]          count;   // 0 .. FIFO_DEPTH

    // storage, no reset on payload
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // ==============================
    // pointers and count
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1; // wraps on power-of-two depth
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // idle or push+pop
            endcase
        end
    end

    assign head  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == FIFO_DEPTH);

    // producer must respect full, consumer must respect empty
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        !(push && full && !pop));
    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        !(pop && empty));

endmodule

// ==== logic/rr_arb.sv ====
// three-way round-robin arbiter, combinational grant, pointer rotates on advance
module rr_arb (
    input  logic       clk,
    input  logic       rst,
    input  logic [2:0] req,
    input  logic       advance,  // granted requester was served
    output logic [2:0] grant
);

    logic [1:0] ptr; // highest priority index, 0..2

    // first requester at or after ptr
    always_comb begin
        int  idx;
        logic found;
        grant = 3'b000;
        found = 1'b0;
        idx   = 0;
        for (int i = 0; i < 3; i++) begin
            idx = (int'(ptr) + i) % 3;
            if (!found && req[idx]) begin
                grant[idx] = 1'b1;
                found      = 1'b1;
            end
        end
    end

    // ==============================
    // priority pointer
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= 2'd0;
        end else if (advance) begin
            case (grant)
                3'b001:  ptr <= 2'd1; // one past the winner
                3'b010:  ptr <= 2'd2;
                3'b100:  ptr <= 2'd0;
                default: ptr <= ptr;
            endcase
        end
    end

    // grant is one-hot or zero and only goes to a requester
    a_grant_legal: assert property (@(posedge clk) disable iff (rst)
        $onehot0(grant) && ((grant & ~req) == 3'b000));

    // served requester must have been granted
    a_advance_granted: assert property (@(posedge clk) disable iff (rst)
        advance |-> (grant != 3'b000));

endmodule

// ==== logic/fifo_arb.sv ====
// output port arbiter: three input fifos, round-robin winner, XY next-hop rewrite
module fifo_arb #(
    parameter int               FIFO_DEPTH = 4,
    parameter router_pkg::t_dir OUT_DIR    = router_pkg::NORTH
) (
    input  logic                    clk,
    input  logic                    rst,
    input  router_pkg::t_tile_id    local_tile_id,
    input  logic                    valid_alloc_req0,
    input  logic                    valid_alloc_req1,
    input  logic                    valid_alloc_req2,
    input  router_pkg::t_tile_trans alloc_req0,
    input  router_pkg::t_tile_trans alloc_req1,
    input  router_pkg::t_tile_trans alloc_req2,
    output logic                    out_ready_fifo0,
    output logic                    out_ready_fifo1,
    output logic                    out_ready_fifo2,
    output logic                    valid_winner_req,
    output router_pkg::t_tile_trans winner_req,
    input  router_pkg::t_fab_ready  in_ready
);

    logic [2:0]              alloc_valid;
    router_pkg::t_tile_trans alloc [3];
    router_pkg::t_tile_trans heads [3];
    logic [2:0]              fifo_full, fifo_empty, push, pop;
    logic [2:0]              arb_req, grant, held_grant;
    logic                    locked;      // winner stalled last cycle
    logic                    accept;      // transfer this cycle
    logic                    hop_ready;
    router_pkg::t_tile_id    nbr_id;      // tile on the other side of this port
    router_pkg::t_tile_trans head_sel;
    router_pkg::t_dir        next_hop;

    assign alloc_valid = {valid_alloc_req2, valid_alloc_req1, valid_alloc_req0};
    assign alloc[0]    = alloc_req0;
    assign alloc[1]    = alloc_req1;
    assign alloc[2]    = alloc_req2;

    // ==============================
    // input fifos
    // ==============================
    for (genvar i = 0; i < 3; i++) begin : g_fifo
        assign push[i] = alloc_valid[i] && !fifo_full[i]; // accepted from neighbor
        fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
            .clk       (clk),
            .rst       (rst),
            .push      (push[i]),
            .push_data (alloc[i]),
            .pop       (pop[i]),
            .head      (heads[i]),
            .empty     (fifo_empty[i]),
            .full      (fifo_full[i])
        );
    end

    assign out_ready_fifo0 = !fifo_full[0];
    assign out_ready_fifo1 = !fifo_full[1];
    assign out_ready_fifo2 = !fifo_full[2];

    // stalled winner keeps the only request so the grant cannot move
    assign arb_req = locked ? held_grant : ~fifo_empty;

    rr_arb u_rr_arb (
        .clk     (clk),
        .rst     (rst),
        .req     (arb_req),
        .advance (accept),
        .grant   (grant)
    );

    always_comb begin
        head_sel = heads[0];
        if (grant[1]) head_sel = heads[1];
        if (grant[2]) head_sel = heads[2];
    end

    // neighbor coordinate, one step toward OUT_DIR
    always_comb begin
        nbr_id = local_tile_id;
        case (OUT_DIR)
            router_pkg::NORTH: nbr_id.y = local_tile_id.y + 1'b1;
            router_pkg::SOUTH: nbr_id.y = local_tile_id.y - 1'b1;
            router_pkg::EAST:  nbr_id.x = local_tile_id.x + 1'b1;
            router_pkg::WEST:  nbr_id.x = local_tile_id.x - 1'b1;
            default:           nbr_id = local_tile_id;
        endcase
    end

    // XY routing: x first, then y
    always_comb begin
        if (head_sel.target_tile_id.x > nbr_id.x)      next_hop = router_pkg::EAST;
        else if (head_sel.target_tile_id.x < nbr_id.x) next_hop = router_pkg::WEST;
        else if (head_sel.target_tile_id.y > nbr_id.y) next_hop = router_pkg::NORTH;
        else if (head_sel.target_tile_id.y < nbr_id.y) next_hop = router_pkg::SOUTH;
        else                                           next_hop = router_pkg::LOCAL;
    end

    always_comb begin
        case (next_hop)
            router_pkg::NORTH: hop_ready = in_ready.north_arb;
            router_pkg::EAST:  hop_ready = in_ready.east_arb;
            router_pkg::SOUTH: hop_ready = in_ready.south_arb;
            router_pkg::WEST:  hop_ready = in_ready.west_arb;
            default:           hop_ready = in_ready.local_arb;
        endcase
    end

    always_comb begin
        winner_req                       = head_sel;
        winner_req.next_tile_fifo_arb_id = next_hop;
    end

    assign valid_winner_req = |grant;
    assign accept           = valid_winner_req && hop_ready;
    assign pop              = grant & {3{accept}};

    always_ff @(posedge clk) begin
        if (rst) begin
            locked     <= 1'b0;
            held_grant <= 3'b000;
        end else begin
            locked     <= valid_winner_req && !accept;
            held_grant <= grant;
        end
    end

    // presented winner stays put until the neighbor takes it
    a_winner_stable: assert property (@(posedge clk) disable iff (rst)
        valid_winner_req && !accept |=> valid_winner_req && $stable(winner_req));

endmodule

// ==== logic/router.sv ====
// mesh tile router: steers each neighbor input to its output arbiter
module router #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  router_pkg::t_tile_id    local_tile_id,
    // ==============================
    // north
    // ==============================
    input  logic                    in_north_req_valid,
    input  router_pkg::t_tile_trans in_north_req,
    output router_pkg::t_fab_ready  out_north_ready,   // east, south, west arbs
    output logic                    out_north_req_valid,
    output router_pkg::t_tile_trans out_north_req,
    input  router_pkg::t_fab_ready  in_north_ready,
    // ==============================
    // east
    // ==============================
    input  logic                    in_east_req_valid,
    input  router_pkg::t_tile_trans in_east_req,
    output router_pkg::t_fab_ready  out_east_ready,    // north, south, west arbs
    output logic                    out_east_req_valid,
    output router_pkg::t_tile_trans out_east_req,
    input  router_pkg::t_fab_ready  in_east_ready,
    // ==============================
    // west
    // ==============================
    input  logic                    in_west_req_valid,
    input  router_pkg::t_tile_trans in_west_req,
    output router_pkg::t_fab_ready  out_west_ready,    // north, east, south arbs
    output logic                    out_west_req_valid,
    output router_pkg::t_tile_trans out_west_req,
    input  router_pkg::t_fab_ready  in_west_ready,
    // ==============================
    // south
    // ==============================
    input  logic                    in_south_req_valid,
    input  router_pkg::t_tile_trans in_south_req,
    output router_pkg::t_fab_ready  out_south_ready,   // north, east, west arbs
    output logic                    out_south_req_valid,
    output router_pkg::t_tile_trans out_south_req,
    input  router_pkg::t_fab_ready  in_south_ready
);

    // fifo ready per arbiter, index = fifo slot of that arbiter
    logic [2:0] north_rdy, east_rdy, south_rdy, west_rdy;

    // next-hop match per input/output pair
    logic s_to_n, e_to_n, w_to_n;
    logic n_to_e, s_to_e, w_to_e;
    logic n_to_s, e_to_s, w_to_s;
    logic n_to_w, e_to_w, s_to_w;

    assign s_to_n = in_south_req_valid && (in_south_req.next_tile_fifo_arb_id == router_pkg::NORTH);
    assign e_to_n = in_east_req_valid  && (in_east_req.next_tile_fifo_arb_id  == router_pkg::NORTH);
    assign w_to_n = in_west_req_valid  && (in_west_req.next_tile_fifo_arb_id  == router_pkg::NORTH);
    assign n_to_e = in_north_req_valid && (in_north_req.next_tile_fifo_arb_id == router_pkg::EAST);
    assign s_to_e = in_south_req_valid && (in_south_req.next_tile_fifo_arb_id == router_pkg::EAST);
    assign w_to_e = in_west_req_valid  && (in_west_req.next_tile_fifo_arb_id  == router_pkg::EAST);
    assign n_to_s = in_north_req_valid && (in_north_req.next_tile_fifo_arb_id == router_pkg::SOUTH);
    assign e_to_s = in_east_req_valid  && (in_east_req.next_tile_fifo_arb_id  == router_pkg::SOUTH);
    assign w_to_s = in_west_req_valid  && (in_west_req.next_tile_fifo_arb_id  == router_pkg::SOUTH);
    assign n_to_w = in_north_req_valid && (in_north_req.next_tile_fifo_arb_id == router_pkg::WEST);
    assign e_to_w = in_east_req_valid  && (in_east_req.next_tile_fifo_arb_id  == router_pkg::WEST);
    assign s_to_w = in_south_req_valid && (in_south_req.next_tile_fifo_arb_id == router_pkg::WEST);

    // fifo slots: north {S,E,W}, east {N,S,W}, south {N,E,W}, west {N,E,S}
    fifo_arb #(.FIFO_DEPTH(FIFO_DEPTH), .OUT_DIR(router_pkg::NORTH)) fifo_arb_north (
        .clk (clk), .rst (rst), .local_tile_id (local_tile_id),
        .valid_alloc_req0 (s_to_n),       .alloc_req0 (in_south_req),
        .valid_alloc_req1 (e_to_n),       .alloc_req1 (in_east_req),
        .valid_alloc_req2 (w_to_n),       .alloc_req2 (in_west_req),
        .out_ready_fifo0  (north_rdy[0]), .out_ready_fifo1 (north_rdy[1]),
        .out_ready_fifo2  (north_rdy[2]),
        .valid_winner_req (out_north_req_valid), .winner_req (out_north_req),
        .in_ready         (in_north_ready)
    );

    fifo_arb #(.FIFO_DEPTH(FIFO_DEPTH), .OUT_DIR(router_pkg::EAST)) fifo_arb_east (
        .clk (clk), .rst (rst), .local_tile_id (local_tile_id),
        .valid_alloc_req0 (n_to_e),       .alloc_req0 (in_north_req),
        .valid_alloc_req1 (s_to_e),       .alloc_req1 (in_south_req),
        .valid_alloc_req2 (w_to_e),       .alloc_req2 (in_west_req),
        .out_ready_fifo0  (east_rdy[0]),  .out_ready_fifo1 (east_rdy[1]),
        .out_ready_fifo2  (east_rdy[2]),
        .valid_winner_req (out_east_req_valid), .winner_req (out_east_req),
        .in_ready         (in_east_ready)
    );

    fifo_arb #(.FIFO_DEPTH(FIFO_DEPTH), .OUT_DIR(router_pkg::SOUTH)) fifo_arb_south (
        .clk (clk), .rst (rst), .local_tile_id (local_tile_id),
        .valid_alloc_req0 (n_to_s),       .alloc_req0 (in_north_req),
        .valid_alloc_req1 (e_to_s),       .alloc_req1 (in_east_req),
        .valid_alloc_req2 (w_to_s),       .alloc_req2 (in_west_req),
        .out_ready_fifo0  (south_rdy[0]), .out_ready_fifo1 (south_rdy[1]),
        .out_ready_fifo2  (south_rdy[2]),
        .valid_winner_req (out_south_req_valid), .winner_req (out_south_req),
        .in_ready         (in_south_ready)
    );

    fifo_arb #(.FIFO_DEPTH(FIFO_DEPTH), .OUT_DIR(router_pkg::WEST)) fifo_arb_west (
        .clk (clk), .rst (rst), .local_tile_id (local_tile_id),
        .valid_alloc_req0 (n_to_w),       .alloc_req0 (in_north_req),
        .valid_alloc_req1 (e_to_w),       .alloc_req1 (in_east_req),
        .valid_alloc_req2 (s_to_w),       .alloc_req2 (in_south_req),
        .out_ready_fifo0  (west_rdy[0]),  .out_ready_fifo1 (west_rdy[1]),
        .out_ready_fifo2  (west_rdy[2]),
        .valid_winner_req (out_west_req_valid), .winner_req (out_west_req),
        .in_ready         (in_west_ready)
    );

    // ==============================
    // ready back to each neighbor
    // ==============================
    always_comb begin
        out_north_ready           = '0;            // u-turn and local stay low
        out_north_ready.east_arb  = east_rdy[0];
        out_north_ready.south_arb = south_rdy[0];
        out_north_ready.west_arb  = west_rdy[0];

        out_east_ready            = '0;
        out_east_ready.north_arb  = north_rdy[1];
        out_east_ready.south_arb  = south_rdy[1];
        out_east_ready.west_arb   = west_rdy[1];

        out_south_ready           = '0;
        out_south_ready.north_arb = north_rdy[0];
        out_south_ready.east_arb  = east_rdy[1];
        out_south_ready.west_arb  = west_rdy[2];

        out_west_ready            = '0;
        out_west_ready.north_arb  = north_rdy[2];
        out_west_ready.east_arb   = east_rdy[2];
        out_west_ready.south_arb  = south_rdy[2];
    end

    // neighbors never send a u-turn or a local hop into this router
    a_north_hop: assert property (@(posedge clk) disable iff (rst) in_north_req_valid |->
        !(in_north_req.next_tile_fifo_arb_id inside {router_pkg::NORTH, router_pkg::LOCAL}));
    a_east_hop: assert property (@(posedge clk) disable iff (rst) in_east_req_valid |->
        !(in_east_req.next_tile_fifo_arb_id inside {router_pkg::EAST, router_pkg::LOCAL}));
    a_south_hop: assert property (@(posedge clk) disable iff (rst) in_south_req_valid |->
        !(in_south_req.next_tile_fifo_arb_id inside {router_pkg::SOUTH, router_pkg::LOCAL}));
    a_west_hop: assert property (@(posedge clk) disable iff (rst) in_west_req_valid |->
        !(in_west_req.next_tile_fifo_arb_id inside {router_pkg::WEST, router_pkg::LOCAL}));

endmodule

// ==== tests/router_tb.sv ====
// router testbench driving random neighbor traffic on all four sides against a queue model
module router_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int FIFO_DEPTH = 4;
    localparam int TIMEOUT    = 2000; // cycles per wait loop
    localparam router_pkg::t_tile_id LOCAL_ID = '{y: 2'd2, x: 2'd1};

    logic                    clk;
    logic                    rst;
    logic                    in_valid  [4]; // arrays indexed by t_dir value
    router_pkg::t_tile_trans in_req    [4];
    router_pkg::t_fab_ready  in_rdy    [4];
    router_pkg::t_fab_ready  out_rdy   [4];
    logic                    out_valid [4];
    router_pkg::t_tile_trans out_req   [4];

    // ==============================
    // model state
    // ==============================
    router_pkg::t_tile_trans exp_q [4][4][$]; // [input][output] in entry order
    router_pkg::t_tile_trans last_out [4];
    logic        stalled [4];   // winner shown but not taken at last edge
    int          fair_wait [4]; // north transfers since own
    int          mode;          // 0 drain, 1 random, 2 three into north, 3 east blocked
    int          phase_left;
    logic        phase_high;
    int          bp_cnt;
    int          val_errs;
    int          other_errs;
    int          timeouts;

    router #(.FIFO_DEPTH(FIFO_DEPTH)) u_router (
        .clk (clk), .rst (rst), .local_tile_id (LOCAL_ID),
        .in_north_req_valid (in_valid[0]), .in_north_req (in_req[0]),
        .out_north_ready (out_rdy[0]), .out_north_req_valid (out_valid[0]),
        .out_north_req (out_req[0]), .in_north_ready (in_rdy[0]),
        .in_east_req_valid (in_valid[1]), .in_east_req (in_req[1]),
        .out_east_ready (out_rdy[1]), .out_east_req_valid (out_valid[1]),
        .out_east_req (out_req[1]), .in_east_ready (in_rdy[1]),
        .in_south_req_valid (in_valid[2]), .in_south_req (in_req[2]),
        .out_south_ready (out_rdy[2]), .out_south_req_valid (out_valid[2]),
        .out_south_req (out_req[2]), .in_south_ready (in_rdy[2]),
        .in_west_req_valid (in_valid[3]), .in_west_req (in_req[3]),
        .out_west_ready (out_rdy[3]), .out_west_req_valid (out_valid[3]),
        .out_west_req (out_req[3]), .in_west_ready (in_rdy[3])
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ==============================
    // compare tasks
    // ==============================
    task automatic check_trans(string name, router_pkg::t_tile_trans got,
                               router_pkg::t_tile_trans want);
        if (got !== want) begin
            val_errs++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, want);
        end
    endtask

    task automatic check_dir(string name, router_pkg::t_dir got, router_pkg::t_dir want);
        if (got !== want) begin
            val_errs++;
            $display("ERR %0t %s got %s expected %s", $time, name, got.name(), want.name());
        end
    endtask

    task automatic check_ready(string name, router_pkg::t_fab_ready got,
                               router_pkg::t_fab_ready want);
        if (got !== want) begin
            val_errs++;
            $display("ERR %0t %s got %b expected %b", $time, name, got, want);
        end
    endtask

    task automatic check_bit(string name, logic got, logic want);
        if (got !== want) begin
            val_errs++;
            $display("ERR %0t %s got %b expected %b", $time, name, got, want);
        end
    endtask

    function automatic string side(int d);
        case (d)
            0:       return "north";
            1:       return "east";
            2:       return "south";
            default: return "west";
        endcase
    endfunction

    // ready bit for arbiter d with north as the msb of the struct
    function automatic logic hop_bit(router_pkg::t_fab_ready r, router_pkg::t_dir d);
        logic [4:0] v;
        v = r;
        return v[3'd4 - d];
    endfunction

    // every arbiter except the u-turn one and local
    function automatic router_pkg::t_fab_ready exp_ready(int x);
        logic [4:0] v;
        v = '0;
        for (int d = 0; d < 4; d++) begin
            if (d != x) v[4-d] = 1'b1;
        end
        return router_pkg::t_fab_ready'(v);
    endfunction

    // XY rule seen from the neighbor on side out_dir with wrapping coordinates
    function automatic router_pkg::t_dir xy_hop(int out_dir, router_pkg::t_tile_id tgt);
        router_pkg::t_tile_id nbr;
        nbr = LOCAL_ID;
        case (out_dir)
            0:       nbr.y = LOCAL_ID.y + 2'd1;
            1:       nbr.x = LOCAL_ID.x + 2'd1;
            2:       nbr.y = LOCAL_ID.y - 2'd1;
            default: nbr.x = LOCAL_ID.x - 2'd1;
        endcase
        if (tgt.x > nbr.x) return router_pkg::EAST;
        if (tgt.x < nbr.x) return router_pkg::WEST;
        if (tgt.y > nbr.y) return router_pkg::NORTH;
        if (tgt.y < nbr.y) return router_pkg::SOUTH;
        return router_pkg::LOCAL;
    endfunction

    function automatic logic busy();
        logic b;
        b = 1'b0;
        for (int d = 0; d < 4; d++) begin
            b |= in_valid[d] || out_valid[d];
            for (int s = 0; s < 4; s++) b |= (exp_q[s][d].size() != 0);
        end
        return b;
    endfunction

    task automatic report_leftover();
        for (int d = 0; d < 4; d++) begin
            if (in_valid[d]) $display("%s input is still holding a transaction", side(d));
            for (int s = 0; s < 4; s++) begin
                if (exp_q[s][d].size() != 0) begin
                    other_errs++;
                    $display("%0d transactions from %s never left on %s",
                             exp_q[s][d].size(), side(s), side(d));
                end
            end
        end
    endtask

    // ==============================
    // stimulus
    // ==============================
    function automatic logic wants_new(int x);
        case (mode)
            1:       return $urandom_range(3, 0) != 0;
            2:       return x != 0; // south, east, west all into north
            3:       return x == 0; // north into a blocked east
            default: return 1'b0;
        endcase
    endfunction

    function automatic router_pkg::t_tile_trans new_trans(int x);
        router_pkg::t_tile_trans t;
        int h;
        h = (x + 1 + int'($urandom_range(2, 0))) % 4; // any side but its own
        if (mode == 2) h = 0;
        if (mode == 3) h = 1;
        t.data                  = $urandom();
        t.address               = $urandom();
        t.opcode                = router_pkg::t_opcode'(2'($urandom()));
        t.requestor_id          = router_pkg::t_tile_id'(4'($urandom()));
        t.target_tile_id        = router_pkg::t_tile_id'(4'($urandom()));
        t.next_tile_fifo_arb_id = router_pkg::t_dir'(3'(h));
        return t;
    endfunction

    task automatic drive_inputs(input logic acc [4]);
        for (int x = 0; x < 4; x++) begin
            if (!in_valid[x] || acc[x]) begin // free to start the next one
                if (wants_new(x)) begin
                    in_req[x]   <= new_trans(x);
                    in_valid[x] <= 1'b1;
                end else begin
                    in_valid[x] <= 1'b0;
                end
            end
        end
        if (mode == 1) begin
            if (phase_left == 0) begin
                phase_high = ($urandom_range(1, 0) == 1);
                phase_left = $urandom_range(60, 20);
            end
            phase_left--;
        end
        for (int d = 0; d < 4; d++) begin
            if (mode == 1 && !phase_high) begin
                in_rdy[d] <= router_pkg::t_fab_ready'(5'($urandom() & $urandom())); // ~1/4 high
            end else if (mode == 3 && d == 1) begin
                in_rdy[d] <= '0;
            end else begin
                in_rdy[d] <= '1;
            end
        end
    endtask

    // ==============================
    // monitor
    // ==============================
    task automatic check_output(int d);
        router_pkg::t_tile_trans want;
        int    src;
        string name;
        name = $sformatf("out_%s_req", side(d));
        if (stalled[d]) begin // held winner must not move
            check_bit({name, "_valid"}, out_valid[d], 1'b1);
            check_trans(name, out_req[d], last_out[d]);
        end
        stalled[d]  = out_valid[d] && !hop_bit(in_rdy[d], out_req[d].next_tile_fifo_arb_id);
        last_out[d] = out_req[d];
        if (out_valid[d] && !stalled[d]) begin
            src = -1;
            for (int s = 0; s < 4; s++) begin
                if (src < 0 && exp_q[s][d].size() != 0
                    && exp_q[s][d][0].requestor_id == out_req[d].requestor_id
                    && exp_q[s][d][0].data == out_req[d].data) src = s;
            end
            if (src < 0) begin
                other_errs++;
                $display("%0t: %s output sent a transaction nobody queued", $time, side(d));
            end else begin
                want = exp_q[src][d].pop_front();
                check_trans(name, out_req[d], want);
                check_dir({name, ".next_tile_fifo_arb_id"},
                          out_req[d].next_tile_fifo_arb_id, want.next_tile_fifo_arb_id);
                if (mode == 2 && d == 0) begin
                    if (fair_wait[src] > 2) begin
                        other_errs++;
                        $display("%0t: %s input waited %0d north grants", $time, side(src),
                                 fair_wait[src]);
                    end
                    for (int s = 0; s < 4; s++) fair_wait[s]++;
                    fair_wait[src] = 0;
                end
            end
        end
    endtask

    // one clock edge that samples pre-edge values and then drives the next inputs
    task automatic step();
        logic acc [4];
        router_pkg::t_tile_trans want;
        int h;
        @(posedge clk);
        for (int x = 0; x < 4; x++) acc[x] = 1'b0;
        if (!rst) begin
            for (int d = 0; d < 4; d++) check_output(d);
            for (int x = 0; x < 4; x++) begin
                h = int'(in_req[x].next_tile_fifo_arb_id);
                if (in_valid[x] && hop_bit(out_rdy[x], in_req[x].next_tile_fifo_arb_id)) begin
                    want = in_req[x];
                    want.next_tile_fifo_arb_id = xy_hop(h, in_req[x].target_tile_id);
                    exp_q[x][h].push_back(want);
                    acc[x] = 1'b1;
                    if (mode == 3 && x == 0) bp_cnt++;
                end
            end
        end
        drive_inputs(acc);
    endtask

    task automatic drain(string phase);
        int n;
        mode = 0;
        for (n = 0; n < TIMEOUT && busy(); n++) step();
        if (busy()) begin
            timeouts++;
            $display("timeout: traffic did not drain after the %s phase", phase);
            report_leftover();
        end
    endtask

    // ==============================
    // test sequence
    // ==============================
    initial begin
        int n;
        void'($urandom(11));
        rst <= 1'b1;
        mode = 0;
        phase_left = 0;
        phase_high = 1'b1;
        bp_cnt = 0;
        val_errs = 0;
        other_errs = 0;
        timeouts = 0;
        for (int d = 0; d < 4; d++) begin
            in_valid[d] <= 1'b0;
            in_req[d]   <= '0;
            in_rdy[d]   <= '1;
            stalled[d]  = 1'b0;
            fair_wait[d] = 0;
        end
        repeat (5) step();
        rst <= 1'b0;
        step();
        for (int d = 0; d < 4; d++) begin
            check_bit($sformatf("out_%s_req_valid", side(d)), out_valid[d], 1'b0);
            check_ready($sformatf("out_%s_ready", side(d)), out_rdy[d], exp_ready(d));
        end

        mode = 1; // random traffic with ready phases
        repeat (3000) step();
        drain("random");

        mode = 2; // fairness on north
        repeat (300) step();
        drain("fairness");

        mode = 3; // east output blocked
        bp_cnt = 0;
        for (n = 0; n < TIMEOUT && bp_cnt < FIFO_DEPTH; n++) step();
        if (bp_cnt < FIFO_DEPTH) begin
            timeouts++;
            $display("timeout: north input never filled the east fifo");
        end
        repeat (3) step();
        check_bit("out_north_ready.east_arb", out_rdy[0].east_arb, 1'b0);
        if (bp_cnt != FIFO_DEPTH) begin
            other_errs++;
            $display("east fifo took %0d transactions while full", bp_cnt);
        end
        drain("back-pressure");

        $display("errors: %0d value, %0d other, %0d timeouts", val_errs, other_errs, timeouts);
        if (val_errs + other_errs + timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
logic/router_pkg.sv
logic/fifo.sv
logic/rr_arb.sv
logic/fifo_arb.sv
logic/router.sv
tests/router_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the router testbench with Verilator, run it, pass only on the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module router_tb \
    -f sim.f -o router_sim || exit 1

out=$(./obj_dir/router_sim)
echo "$out"
echo "$out" | grep -qx "Simulation PASSED" && exit 0 || exit 1
